// File: cicero_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// shared widths, types and encodings of the regex coprocessor
// one memory word holds exactly CHARS_PER_WORD characters
// character 0 of a word sits in its low byte
// a byte pointer is the word address with the character id below it
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cicero_pkg;

    // character and memory geometry
    localparam int CHAR_WIDTH     = 8;
    localparam int CHARS_PER_WORD = 4;
    localparam int MEM_WIDTH      = CHAR_WIDTH * CHARS_PER_WORD;
    localparam int CHAR_ID_BITS   = $clog2(CHARS_PER_WORD);
    localparam int MEM_ADDR_WIDTH = 10;
    // byte pointer covers every character of the word space
    localparam int PTR_WIDTH      = MEM_ADDR_WIDTH + CHAR_ID_BITS;

    // engine program store
    localparam int PROG_DEPTH     = 8;
    localparam int PC_WIDTH       = $clog2(PROG_DEPTH);

    typedef logic [CHAR_WIDTH-1:0]     char_t;
    typedef logic [MEM_WIDTH-1:0]      word_t;
    typedef logic [PTR_WIDTH-1:0]      ptr_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;

    // program operations
    // OP_OPT_CHAR may also be skipped without consuming a character
    typedef enum logic [1:0] {
        OP_CHAR     = 2'd0,
        OP_ANY      = 2'd1,
        OP_OPT_CHAR = 2'd2,
        OP_ACCEPT   = 2'd3
    } opcode_e;

    // whole program as seen by the engine
    typedef opcode_e op_vec_t   [PROG_DEPTH];
    typedef char_t   char_vec_t [PROG_DEPTH];

    // job supervisor states
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_FETCH       = 3'd1,
        ST_LOAD        = 3'd2,
        ST_STEP        = 3'd3,
        ST_CHECK       = 3'd4,
        ST_DONE_ACCEPT = 3'd5,
        ST_DONE_REJECT = 3'd6,
        ST_ERROR       = 3'd7
    } sup_state_e;

endpackage

`default_nettype wire

// File: prog_store.sv
//~~~~~~~~~~~~~~~~~~~~
// engine program register file
// one entry written per prog_we strobe
// all entries readable at once, no read latency
// writing while a job runs is not supported
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module prog_store
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  prog_we,
    input  wire cicero_pkg::pc_t       prog_addr,
    input  wire cicero_pkg::opcode_e   prog_op,
    input  wire cicero_pkg::char_t     prog_char,
    output cicero_pkg::op_vec_t        rd_op,
    output cicero_pkg::char_vec_t      rd_char
);

    // opcodes come out of reset as accept
    // so an unwritten program matches everything
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
            begin
                rd_op[i] <= cicero_pkg::OP_ACCEPT;
            end
        end
        else if (prog_we)
        begin
            rd_op[prog_addr] <= prog_op;
        end
    end

    // literal is only looked at for char and opt_char entries
    always_ff @(posedge clk)
    begin
        if (prog_we)
        begin
            rd_char[prog_addr] <= prog_char;
        end
    end

endmodule

`default_nettype wire

// File: char_window.sv
//~~~~~~~~~~~~~~~~~~~~
// character window over the string in memory
// holds one memory word and a byte pointer into it
// the word must be loaded before the pointer's character is used
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module char_window
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start_job,
    input  wire cicero_pkg::ptr_t      start_ptr,
    input  wire cicero_pkg::ptr_t      end_ptr,
    input  wire logic                  load_word,
    input  wire cicero_pkg::word_t     memory_data,
    input  wire logic                  advance,
    output cicero_pkg::char_t          cur_char,
    output cicero_pkg::mem_addr_t      cur_word_addr,
    output logic                       at_end,
    output logic                       word_boundary
);

    // current and end byte pointers
    cicero_pkg::ptr_t  ptr_q;
    cicero_pkg::ptr_t  end_q;
    // last word returned by memory
    cicero_pkg::word_t word_q;
    // character id of the current pointer
    logic [cicero_pkg::CHAR_ID_BITS-1:0] char_id;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr_q <= '0;
            end_q <= '0;
        end
        else if (start_job)
        begin
            // new job restarts the window at the first character
            ptr_q <= start_ptr;
            end_q <= end_ptr;
        end
        else if (advance)
        begin
            // one character consumed
            ptr_q <= ptr_q + 1'b1;
        end
    end

    // captured in the cycle after memory accepted the request
    always_ff @(posedge clk)
    begin
        if (load_word)
        begin
            word_q <= memory_data;
        end
    end

    assign char_id = ptr_q[cicero_pkg::CHAR_ID_BITS-1:0];

    // char 0 in the low byte of the word
    assign cur_char = word_q[char_id*cicero_pkg::CHAR_WIDTH +: cicero_pkg::CHAR_WIDTH];

    // word holding the current character
    assign cur_word_addr = ptr_q[cicero_pkg::PTR_WIDTH-1:cicero_pkg::CHAR_ID_BITS];

    // end pointer is exclusive
    assign at_end = (ptr_q == end_q);

    // first character of a word needs a fresh fetch
    assign word_boundary = (char_id == '0);

endmodule

`default_nettype wire

// File: nfa_engine.sv
//~~~~~~~~~~~~~~~~~~~~
// bit-parallel NFA over the program store
// one thread bit per program index
// a thread at the last index cannot move forward
// only opt_char entries add epsilon edges
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module nfa_engine
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  engine_init,
    input  wire logic                  engine_step,
    input  wire cicero_pkg::char_t     cur_char,
    input  wire cicero_pkg::op_vec_t   rd_op,
    input  wire cicero_pkg::char_vec_t rd_char,
    output logic                       accept_hit,
    output logic                       running
);

    // registered thread mask before closure
    logic [cicero_pkg::PROG_DEPTH-1:0] active;
    // mask after epsilon closure
    logic [cicero_pkg::PROG_DEPTH-1:0] closed;
    // closed entries holding accept
    logic [cicero_pkg::PROG_DEPTH-1:0] accepting;
    // mask after consuming cur_char
    logic [cicero_pkg::PROG_DEPTH-1:0] stepped;

    // closure ripples forward through chains of opt_char
    always_comb
    begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            closed[i] = active[i] | carry;
            carry     = closed[i] & (rd_op[i] == cicero_pkg::OP_OPT_CHAR);
        end
    end

    always_comb
    begin
        for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            accepting[i] = closed[i] & (rd_op[i] == cicero_pkg::OP_ACCEPT);
        end
    end

    // thread at i moves to i+1 when its entry takes cur_char
    always_comb
    begin
        stepped[0] = 1'b0;
        for (int i = 1; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            stepped[i] = closed[i-1] &
                         ((rd_op[i-1] == cicero_pkg::OP_ANY) |
                          (((rd_op[i-1] == cicero_pkg::OP_CHAR) |
                            (rd_op[i-1] == cicero_pkg::OP_OPT_CHAR)) &
                           (rd_char[i-1] == cur_char)));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active <= '0;
        end
        else if (engine_init)
        begin
            // anchored start at index 0
            active <= {{(cicero_pkg::PROG_DEPTH-1){1'b0}}, 1'b1};
        end
        else if (engine_step)
        begin
            active <= stepped;
        end
    end

    assign accept_hit = |accepting;
    assign running    = |closed;

endmodule

`default_nettype wire

// File: regex_supervisor.sv
//~~~~~~~~~~~~~~~~~~~~
// job FSM of the coprocessor
// start_ptr must be word aligned, otherwise error latches until rst
// jobs are taken only in idle, one character per step
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module regex_supervisor
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  valid,
    input  wire cicero_pkg::ptr_t      start_ptr,
    input  wire logic                  memory_ready,
    input  wire cicero_pkg::mem_addr_t cur_word_addr,
    input  wire logic                  at_end,
    input  wire logic                  word_boundary,
    input  wire logic                  accept_hit,
    input  wire logic                  running,
    output logic                       ready,
    output logic                       start_job,
    output logic                       load_word,
    output logic                       advance,
    output logic                       engine_init,
    output logic                       engine_step,
    output logic                       memory_valid,
    output cicero_pkg::mem_addr_t      memory_addr,
    output logic                       done,
    output logic                       accept,
    output logic                       error
);

    cicero_pkg::sup_state_e state;
    cicero_pkg::sup_state_e state_nxt;
    // start pointer not on a word boundary
    logic misaligned;

    assign misaligned = (start_ptr[cicero_pkg::CHAR_ID_BITS-1:0] != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= cicero_pkg::ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            cicero_pkg::ST_IDLE:
            begin
                if (valid)
                begin
                    state_nxt = misaligned ? cicero_pkg::ST_ERROR : cicero_pkg::ST_CHECK;
                end
            end
            cicero_pkg::ST_CHECK:
            begin
                // accept wins over end of string
                if (accept_hit)
                    state_nxt = cicero_pkg::ST_DONE_ACCEPT;
                else if (!running || at_end)
                    state_nxt = cicero_pkg::ST_DONE_REJECT;
                else if (word_boundary)
                    state_nxt = cicero_pkg::ST_FETCH;
                else
                    state_nxt = cicero_pkg::ST_STEP;
            end
            cicero_pkg::ST_FETCH:
            begin
                // hold the request until memory takes it
                if (memory_ready)
                    state_nxt = cicero_pkg::ST_LOAD;
            end
            cicero_pkg::ST_LOAD:
                state_nxt = cicero_pkg::ST_STEP;
            cicero_pkg::ST_STEP:
                state_nxt = cicero_pkg::ST_CHECK;
            cicero_pkg::ST_DONE_ACCEPT,
            cicero_pkg::ST_DONE_REJECT:
                state_nxt = cicero_pkg::ST_IDLE;
            cicero_pkg::ST_ERROR:
                // only rst leaves here
                state_nxt = cicero_pkg::ST_ERROR;
        endcase
    end

    // job handshake
    assign ready       = (state == cicero_pkg::ST_IDLE);
    assign start_job   = ready & valid;
    assign engine_init = start_job & ~misaligned;

    // memory request for the word under the pointer
    assign memory_valid = (state == cicero_pkg::ST_FETCH);
    assign memory_addr  = memory_valid ? cur_word_addr : '0;

    // read data arrives in load
    assign load_word = (state == cicero_pkg::ST_LOAD);

    // engine consumes the character while the window moves past it
    assign engine_step = (state == cicero_pkg::ST_STEP);
    assign advance     = (state == cicero_pkg::ST_STEP);

    // job result
    assign accept = (state == cicero_pkg::ST_DONE_ACCEPT);
    assign done   = accept | (state == cicero_pkg::ST_DONE_REJECT);
    assign error  = (state == cicero_pkg::ST_ERROR);

endmodule

`default_nettype wire

// File: regex_coprocessor.sv
//~~~~~~~~~~~~~~~~~~~~
// regex coprocessor top level
// memory read data is expected one cycle after valid and ready meet
// program is written through its own port, never during a job
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module regex_coprocessor
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  valid,
    input  wire cicero_pkg::ptr_t      start_ptr,
    input  wire cicero_pkg::ptr_t      end_ptr,
    input  wire logic                  prog_we,
    input  wire cicero_pkg::pc_t       prog_addr,
    input  wire cicero_pkg::opcode_e   prog_op,
    input  wire cicero_pkg::char_t     prog_char,
    input  wire logic                  memory_ready,
    input  wire cicero_pkg::word_t     memory_data,
    output logic                       ready,
    output logic                       memory_valid,
    output cicero_pkg::mem_addr_t      memory_addr,
    output logic                       done,
    output logic                       accept,
    output logic                       error
);

    // program to engine
    cicero_pkg::op_vec_t   rd_op;
    cicero_pkg::char_vec_t rd_char;
    // window status and control
    cicero_pkg::char_t     cur_char;
    cicero_pkg::mem_addr_t cur_word_addr;
    logic                  at_end;
    logic                  word_boundary;
    logic                  start_job;
    logic                  load_word;
    logic                  advance;
    // engine status and control
    logic                  accept_hit;
    logic                  running;
    logic                  engine_init;
    logic                  engine_step;

    prog_store u_prog_store (
        .clk           (clk),
        .rst           (rst),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_op       (prog_op),
        .prog_char     (prog_char),
        .rd_op         (rd_op),
        .rd_char       (rd_char)
    );

    char_window u_char_window (
        .clk           (clk),
        .rst           (rst),
        .start_job     (start_job),
        .start_ptr     (start_ptr),
        .end_ptr       (end_ptr),
        .load_word     (load_word),
        .memory_data   (memory_data),
        .advance       (advance),
        .cur_char      (cur_char),
        .cur_word_addr (cur_word_addr),
        .at_end        (at_end),
        .word_boundary (word_boundary)
    );

    nfa_engine u_nfa_engine (
        .clk           (clk),
        .rst           (rst),
        .engine_init   (engine_init),
        .engine_step   (engine_step),
        .cur_char      (cur_char),
        .rd_op         (rd_op),
        .rd_char       (rd_char),
        .accept_hit    (accept_hit),
        .running       (running)
    );

    regex_supervisor u_regex_supervisor (
        .clk           (clk),
        .rst           (rst),
        .valid         (valid),
        .start_ptr     (start_ptr),
        .memory_ready  (memory_ready),
        .cur_word_addr (cur_word_addr),
        .at_end        (at_end),
        .word_boundary (word_boundary),
        .accept_hit    (accept_hit),
        .running       (running),
        .ready         (ready),
        .start_job     (start_job),
        .load_word     (load_word),
        .advance       (advance),
        .engine_init   (engine_init),
        .engine_step   (engine_step),
        .memory_valid  (memory_valid),
        .memory_addr   (memory_addr),
        .done          (done),
        .accept        (accept),
        .error         (error)
    );

endmodule

`default_nettype wire

// File: regex_coprocessor_properties.sv
//~~~~~~~~~~~~~~~~~~~~
// protocol properties bound into the coprocessor top
// all checks are off while rst is high
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module regex_coprocessor_properties
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  done,
    input  wire logic                  accept,
    input  wire logic                  error,
    input  wire logic                  memory_valid,
    input  wire logic                  memory_ready,
    input  wire cicero_pkg::mem_addr_t memory_addr
);

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high two cycles running");

    accept_with_done: assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else $error("accept without done");

    // request held while memory stalls
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (memory_valid && !memory_ready) |=> (memory_valid && $stable(memory_addr)))
        else $error("memory request changed before acceptance");

    // error only clears on rst
    error_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else $error("error dropped without reset");

endmodule

bind regex_coprocessor regex_coprocessor_properties u_properties (
    .clk          (clk),
    .rst          (rst),
    .done         (done),
    .accept       (accept),
    .error        (error),
    .memory_valid (memory_valid),
    .memory_ready (memory_ready),
    .memory_addr  (memory_addr)
);

`default_nettype wire

// File: tb_regex_coprocessor.sv
//~~~~~~~~~~~~~~~~~~~~
// testbench for the regex coprocessor
// memory model answers one cycle after acceptance
// strings start word aligned except in the error test
// program store is reloaded after every reset
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_regex_coprocessor;

    localparam int TIMEOUT = 200;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  valid;
    cicero_pkg::ptr_t      start_ptr;
    cicero_pkg::ptr_t      end_ptr;
    logic                  prog_we;
    cicero_pkg::pc_t       prog_addr;
    cicero_pkg::opcode_e   prog_op;
    cicero_pkg::char_t     prog_char;
    logic                  memory_ready;
    cicero_pkg::word_t     memory_data;
    logic                  ready;
    logic                  memory_valid;
    cicero_pkg::mem_addr_t memory_addr;
    logic                  done;
    logic                  accept;
    logic                  error;

    // string memory and the program the model believes is loaded
    cicero_pkg::word_t     mem [1024];
    cicero_pkg::opcode_e   pops [cicero_pkg::PROG_DEPTH];
    cicero_pkg::char_t     pchars [cicero_pkg::PROG_DEPTH];

    int                    seed = 32'hf0ff;
    int                    errors = 0;
    int                    tests = 0;
    logic                  stall_on = 1'b0;
    // words the current job may request
    cicero_pkg::mem_addr_t lo_word = '0;
    cicero_pkg::mem_addr_t hi_word = '0;

    regex_coprocessor dut (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_op      (prog_op),
        .prog_char    (prog_char),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .ready        (ready),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .done         (done),
        .accept       (accept),
        .error        (error)
    );

    always #10 clk = ~clk;

    // memory with random back-pressure when stalls are on
    always @(posedge clk)
    begin
        int r;
        r = $random(seed);
        memory_ready <= stall_on ? r[0] : 1'b1;
        if (memory_valid && memory_ready)
        begin
            memory_data <= mem[memory_addr];
            assert (memory_addr >= lo_word && memory_addr <= hi_word)
            else
            begin
                $display("Mismatch memory_addr: got %h expected %h to %h",
                         memory_addr, lo_word, hi_word);
                errors++;
            end
        end
    end

    function automatic cicero_pkg::char_t byte_at(cicero_pkg::ptr_t p);
        return cicero_pkg::char_t'(mem[p >> 2] >> (8 * p[1:0]));
    endfunction

    // anchored match, accept tested before each character and after the last
    function automatic logic ref_match(cicero_pkg::ptr_t s, cicero_pkg::ptr_t e);
        logic [7:0]        act;
        logic [7:0]        cl;
        logic [7:0]        nx;
        cicero_pkg::ptr_t  p;
        cicero_pkg::char_t c;
        act = 8'b1;
        p = s;
        for (int n = 0; n <= 16; n++)
        begin
            cl = act;
            // opt_char lets a thread skip ahead without a character
            for (int i = 1; i < 8; i++)
            begin
                if (cl[i-1] && pops[i-1] == cicero_pkg::OP_OPT_CHAR)
                    cl[i] = 1'b1;
            end
            for (int i = 0; i < 8; i++)
            begin
                if (cl[i] && pops[i] == cicero_pkg::OP_ACCEPT)
                    return 1'b1;
            end
            if (cl == 8'b0 || p == e)
                return 1'b0;
            c = byte_at(p);
            nx = 8'b0;
            for (int i = 0; i < 7; i++)
            begin
                if (cl[i] && (pops[i] == cicero_pkg::OP_ANY ||
                              (pops[i] != cicero_pkg::OP_ACCEPT && pchars[i] == c)))
                    nx[i+1] = 1'b1;
            end
            act = nx;
            p = p + 1'b1;
        end
        return 1'b0;
    endfunction

    // one output bit against its expected value
    task automatic compare_bit(string sig, logic got, logic exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic set_string(cicero_pkg::ptr_t s, string txt);
        cicero_pkg::ptr_t p;
        for (int k = 0; k < txt.len(); k++)
        begin
            p = s + cicero_pkg::ptr_t'(k);
            mem[p >> 2][8 * p[1:0] +: 8] = txt[k];
        end
    endtask

    task automatic load_prog();
        for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cicero_pkg::pc_t'(i);
            prog_op   <= pops[i];
            prog_char <= pchars[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic check_job(string name, cicero_pkg::ptr_t s, cicero_pkg::ptr_t e);
        logic exp;
        int   n;
        exp = ref_match(s, e);
        lo_word = cicero_pkg::mem_addr_t'(s >> 2);
        hi_word = (e == s) ? lo_word : cicero_pkg::mem_addr_t'((e - 1'b1) >> 2);
        @(posedge clk);
        start_ptr <= s;
        end_ptr   <= e;
        valid     <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!done && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        tests++;
        assert (done)
        else
        begin
            $display("job %s timed out, done never rose", name);
            errors++;
        end
        assert (accept === exp)
        else
        begin
            $display("Mismatch accept in %s: got %h expected %h", name, accept, exp);
            errors++;
        end
        $display("test %s start %h end %h accept %b", name, s, e, accept);
    endtask

    // random program, literals from a small alphabet so matches happen
    task automatic rand_prog();
        int unsigned plen;
        int unsigned r;
        plen = 1 + {$random(seed)} % 6;
        for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            r = {$random(seed)};
            pops[i]   = (i < plen) ? cicero_pkg::opcode_e'(r % 3) : cicero_pkg::OP_ACCEPT;
            pchars[i] = cicero_pkg::char_t'("a" + (r >> 4) % 3);
        end
        load_prog();
    endtask

    task automatic rand_job(string name);
        int unsigned w;
        int unsigned len;
        w = 16 + {$random(seed)} % 400;
        len = {$random(seed)} % 12;
        // end pointer kept off the word boundary
        if (len % 4 == 0)
            len++;
        check_job(name, cicero_pkg::ptr_t'(w * 4), cicero_pkg::ptr_t'(w * 4 + len));
    endtask

    task automatic set_literal_prog();
        for (int i = 0; i < cicero_pkg::PROG_DEPTH; i++)
        begin
            pops[i]   = cicero_pkg::OP_ACCEPT;
            pchars[i] = 8'h00;
        end
        pops[0]   = cicero_pkg::OP_CHAR;
        pchars[0] = "a";
        pops[1]   = cicero_pkg::OP_CHAR;
        pchars[1] = "b";
        load_prog();
    endtask

    initial
    begin
        int unsigned r;
        int          n;
        rst          = 1'b1;
        valid        = 1'b0;
        start_ptr    = '0;
        end_ptr      = '0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_op      = cicero_pkg::OP_CHAR;
        prog_char    = '0;
        memory_ready = 1'b0;
        memory_data  = '0;
        // every byte of every word drawn from "a" to "d"
        for (int a = 0; a < 1024; a++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                r = {$random(seed)};
                mem[a][8*k +: 8] = cicero_pkg::char_t'("a" + r % 4);
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // state straight out of reset
        @(negedge clk);
        tests++;
        compare_bit("ready", ready, 1'b1);
        compare_bit("done", done, 1'b0);
        compare_bit("accept", accept, 1'b0);
        compare_bit("error", error, 1'b0);
        compare_bit("memory_valid", memory_valid, 1'b0);
        $display("test reset ready %b done %b error %b", ready, done, error);

        // literal "ab"
        set_literal_prog();
        set_string(12'd1200, "abcd");
        set_string(12'd1208, "acbd");
        set_string(12'd1216, "a");
        set_string(12'd1224, "ab");
        set_string(12'd1232, "xabx");
        set_string(12'd1240, "abzzzz");
        check_job("lit_abcd", 12'd1200, 12'd1204);
        check_job("lit_acbd", 12'd1208, 12'd1212);
        check_job("lit_a", 12'd1216, 12'd1217);
        check_job("lit_ab", 12'd1224, 12'd1226);
        check_job("lit_xabx", 12'd1232, 12'd1236);
        check_job("lit_abzzzz", 12'd1240, 12'd1246);

        // random programs, memory always ready
        for (int t = 0; t < 40; t++)
        begin
            rand_prog();
            rand_job($sformatf("rand_%0d", t));
        end

        // same with memory stalls
        stall_on = 1'b1;
        for (int t = 0; t < 40; t++)
        begin
            rand_prog();
            rand_job($sformatf("stall_%0d", t));
        end

        // empty strings, closure of index 0 decides
        pops[0] = cicero_pkg::OP_OPT_CHAR;
        pops[1] = cicero_pkg::OP_OPT_CHAR;
        pops[2] = cicero_pkg::OP_ACCEPT;
        load_prog();
        check_job("empty_opt", 12'd1600, 12'd1600);
        pops[1] = cicero_pkg::OP_CHAR;
        load_prog();
        check_job("empty_char", 12'd1600, 12'd1600);
        for (int t = 0; t < 8; t++)
        begin
            rand_prog();
            check_job($sformatf("empty_%0d", t), 12'd1604, 12'd1604);
        end

        // misaligned start
        @(posedge clk);
        start_ptr <= 12'd1601;
        end_ptr   <= 12'd1606;
        valid     <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!error && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        n = 0;
        while (!done && n < 40)
        begin
            @(negedge clk);
            n++;
        end
        tests++;
        compare_bit("error", error, 1'b1);
        compare_bit("ready", ready, 1'b0);
        compare_bit("done", done, 1'b0);
        $display("test misaligned error %b ready %b", error, ready);

        // recovery after a fresh reset
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        set_literal_prog();
        check_job("after_reset", 12'd1224, 12'd1226);

        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: regex_coprocessor.f
cicero_pkg.sv
prog_store.sv
char_window.sv
nfa_engine.sv
regex_supervisor.sv
regex_coprocessor.sv
regex_coprocessor_properties.sv
tb_regex_coprocessor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_regex_coprocessor
LOG       ?= sim.log
SEED      ?= 0
FLIST     ?= regex_coprocessor.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
